/* all.f */
common/rv_pkg.sv
common/fe_pkg.sv
common/bp_resolve_if.sv
common/pred_if.sv
predict/bht.sv
predict/ras.sv
predict/branch_predict.sv
hw/pc_gen.sv
hw/instr_queue.sv
hw/frontend.sv
sim/tb_frontend.sv

/* Bender.yml */
package:
  name: frontend

sources:
  - common/rv_pkg.sv
  - common/fe_pkg.sv
  - common/bp_resolve_if.sv
  - common/pred_if.sv
  - predict/bht.sv
  - predict/ras.sv
  - predict/branch_predict.sv
  - hw/pc_gen.sv
  - hw/instr_queue.sv
  - hw/frontend.sv
  - target: simulation
    files:
      - sim/tb_frontend.sv

/* sim/tb_frontend.sv */
`default_nettype none
`timescale 1ns/100ps

module tb_frontend import fe_pkg::*, rv_pkg::*; ();

    localparam int CLK_PERIOD = 20;
    localparam int N_ENTRIES  = 60;
    localparam int N_EVENTS   = 6;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    // one stimulus row is applied for a single cycle once enough entries have left the queue
    typedef struct packed {
        logic [7:0]  key;
        logic        ex;
        logic        eret;
        logic        res;
        logic        cond;
        logic        misp;
        logic        taken;
        logic [31:0] rpc;
        logic [31:0] trap;
        logic [31:0] epc;
        logic [31:0] rtarget;
        logic [31:0] exp_pc;
    } event_t;

    logic clk_i = 1'b0;
    logic rst_ni;
    logic [VLEN-1:0] boot_addr_i;
    logic mem_req_o, mem_ready_i, mem_rvalid_i;
    logic [VLEN-1:0] mem_addr_o;
    logic [31:0] mem_rdata_i;
    logic resolve_valid_i, resolve_conditional_i, resolve_taken_i, resolve_mispredict_i;
    logic [VLEN-1:0] resolve_pc_i, resolve_target_i, epc_i, trap_vector_i;
    logic eret_i, ex_valid_i;
    logic fetch_valid_o, fetch_ready_i, fetch_taken_o;
    logic [VLEN-1:0] fetch_pc_o, fetch_target_o;
    logic [31:0] fetch_instr_o;

    logic [31:0] prog [256];
    event_t      ev_tab [N_EVENTS];
    integer      seed = 36;
    int          mismatches = 0;
    int          failures = 0;
    int          count = 0;
    int          ev_idx = 0;
    int          occ = 0;

    // reference model state
    logic [31:0] exp_pc;
    logic [1:0]  ref_cnt [BHT_ENTRIES];
    logic        ref_valid [BHT_ENTRIES];
    logic [31:0] ref_ras [RAS_DEPTH];
    int          ref_depth = 0;

    frontend dut_i (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // program assembly
    // ----------------------------------------------------------------------
    function automatic logic [31:0] enc_jal(input logic [4:0] rd, input logic [20:0] off);
        rv_instr_t w;
        w = '0;
        w.j.opcode  = OPC_JAL;
        w.j.rd      = rd;
        w.j.imm20   = off[20];
        w.j.imm10_1 = off[10:1];
        w.j.imm11   = off[11];
        w.j.rs1     = off[19:15];
        w.j.funct3  = off[14:12];
        return w;
    endfunction

    function automatic logic [31:0] enc_branch(input logic [12:0] off);
        rv_instr_t w;
        w = '0;
        w.b.opcode  = OPC_BRANCH;
        w.b.rs1     = 5'd10;
        w.b.rs2     = 5'd11;
        w.b.imm12   = off[12];
        w.b.imm11   = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1  = off[4:1];
        return w;
    endfunction

    function automatic logic [31:0] enc_jalr(input logic [4:0] rd, input logic [4:0] rs1);
        rv_instr_t w;
        w = '0;
        w.j.opcode = OPC_JALR;
        w.j.rd     = rd;
        w.j.rs1    = rs1;
        return w;
    endfunction

    function automatic logic is_link(input logic [4:0] r);
        return (r == 5'd1) || (r == 5'd5);
    endfunction

    // ----------------------------------------------------------------------
    // reference prediction straight from the ISA fields
    // ----------------------------------------------------------------------
    task automatic predict_entry(input logic [31:0] pc, output logic [31:0] instr,
                                 output logic taken, output logic [31:0] target);
        logic [31:0]          w;
        logic [31:0]          boff;
        logic [31:0]          joff;
        logic                 call;
        logic                 ret;
        logic [BHT_IDX_W-1:0] idx;
        w      = prog[pc[9:2]];
        idx    = pc[BHT_IDX_W+1:2];
        boff   = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        joff   = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        call   = (w[6:0] == OPC_JAL || w[6:0] == OPC_JALR) && is_link(w[11:7]);
        ret    = (w[6:0] == OPC_JALR) && is_link(w[19:15]) && (w[11:7] == 5'd0);
        instr  = w;
        taken  = 1'b0;
        target = pc + 32'd4;
        if (w[6:0] == OPC_JAL) begin
            taken  = 1'b1;
            target = pc + joff;
        end else if (w[6:0] == OPC_BRANCH) begin
            // a cold counter falls back to the sign of the offset
            taken = ref_valid[idx] ? ref_cnt[idx][1] : boff[31];
            if (taken) begin
                target = pc + boff;
            end
        end else if (ret && ref_depth > 0) begin
            taken  = 1'b1;
            target = ref_ras[0];
        end
        // stack bookkeeping
        if (call) begin
            for (int i = RAS_DEPTH - 1; i > 0; i--) begin
                ref_ras[i] = ref_ras[i-1];
            end
            ref_ras[0] = pc + 32'd4;
            if (ref_depth < RAS_DEPTH) begin
                ref_depth++;
            end
        end else if (ret && ref_depth > 0) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                ref_ras[i] = ref_ras[i+1];
            end
            ref_depth--;
        end
    endtask

    task automatic train_bht(input logic [31:0] pc, input logic taken);
        logic [BHT_IDX_W-1:0] idx;
        idx = pc[BHT_IDX_W+1:2];
        if (!ref_valid[idx]) begin
            ref_valid[idx] = 1'b1;
            ref_cnt[idx]   = taken ? 2'b10 : 2'b01;
        end else if (taken && ref_cnt[idx] != 2'b11) begin
            ref_cnt[idx] = ref_cnt[idx] + 2'd1;
        end else if (!taken && ref_cnt[idx] != 2'b00) begin
            ref_cnt[idx] = ref_cnt[idx] - 2'd1;
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            mismatches++;
            $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_entry();
        logic [31:0] instr;
        logic        taken;
        logic [31:0] target;
        predict_entry(exp_pc, instr, taken, target);
        compare("fetch_pc_o", fetch_pc_o, exp_pc);
        compare("fetch_instr_o", fetch_instr_o, instr);
        compare("fetch_taken_o", 32'(fetch_taken_o), 32'(taken));
        compare("fetch_target_o", fetch_target_o, target);
        exp_pc = target;
    endtask

    // ----------------------------------------------------------------------
    // stimulus, memory model and checker
    // ----------------------------------------------------------------------
    initial begin
        logic        acc;
        logic [31:0] acc_addr;
        logic        redir_now;
        logic        pending;
        logic        pop;
        event_t      e;
        for (int i = 0; i < 256; i++) begin
            // filler is a plain addi whose immediate follows the word index
            prog[i] = {12'(i * 7 + 1), 5'd0, 3'b000, 5'd0, OPC_OP_IMM};
        end
        for (int i = 0; i < BHT_ENTRIES; i++) begin
            ref_valid[i] = 1'b0;
            ref_cnt[i]   = 2'b00;
        end
        prog[32'h050 >> 2] = enc_jal(REG_ZERO, 21'h50);
        prog[32'h0a4 >> 2] = enc_branch(13'h008);
        prog[32'h0b0 >> 2] = enc_branch(-13'sd80);
        // three nested calls go one deeper than the stack
        prog[32'h0b4 >> 2] = enc_jal(REG_RA, 21'h08c);
        prog[32'h140 >> 2] = enc_jal(REG_RA, 21'h040);
        prog[32'h180 >> 2] = enc_jal(REG_T0, 21'h040);
        prog[32'h1c0 >> 2] = enc_jalr(REG_ZERO, REG_T0);
        prog[32'h184 >> 2] = enc_jalr(REG_ZERO, REG_RA);
        prog[32'h144 >> 2] = enc_jalr(REG_ZERO, REG_RA);
        // key ex eret res cond misp taken rpc trap epc rtarget exp_pc
        ev_tab[0] = '{8'd11, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0a4, 32'h0, 32'h0,
                      32'h0, 32'h0};
        ev_tab[1] = '{8'd11, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, 32'h0b0, 32'h0, 32'h0,
                      32'h0, 32'h0};
        ev_tab[2] = '{8'd40, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0, 32'h300, 32'h280,
                      32'h200, 32'h300};
        ev_tab[3] = '{8'd44, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h0, 32'h280,
                      32'h0, 32'h280};
        ev_tab[4] = '{8'd48, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 32'h0, 32'h0, 32'h0,
                      32'h200, 32'h200};
        ev_tab[5] = '{8'd52, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 32'h0, 32'h340, 32'h0,
                      32'h0, 32'h340};
        boot_addr_i = 32'h040;
        exp_pc = boot_addr_i;
        rst_ni = 1'b0;
        mem_ready_i = 1'b0;
        mem_rvalid_i = 1'b0;
        mem_rdata_i = '0;
        resolve_valid_i = 1'b0;
        resolve_conditional_i = 1'b0;
        resolve_pc_i = '0;
        resolve_taken_i = 1'b0;
        resolve_mispredict_i = 1'b0;
        resolve_target_i = '0;
        eret_i = 1'b0;
        epc_i = '0;
        ex_valid_i = 1'b0;
        trap_vector_i = '0;
        fetch_ready_i = 1'b0;
        repeat (5) @(posedge clk_i);
        rst_ni <= 1'b1;
        while (count < N_ENTRIES) begin
            @(negedge clk_i);
            acc       = mem_req_o & mem_ready_i;
            acc_addr  = mem_addr_o;
            redir_now = ex_valid_i | eret_i | (resolve_valid_i & resolve_mispredict_i);
            pending   = mem_rvalid_i & ~redir_now;
            pop       = fetch_valid_o & fetch_ready_i;
            if (mem_req_o) begin
                assert (occ + pending <= QUEUE_DEPTH - 2) else begin
                    failures++;
                    $display("t=%0t request raised with fewer than two free queue slots", $time);
                end
                assert (!redir_now) else begin
                    failures++;
                    $display("t=%0t request raised while a redirect is applied", $time);
                end
            end
            assert (fetch_valid_o == (occ != 0 && !redir_now)) else begin
                failures++;
                $display("t=%0t queue valid does not match the words written into it", $time);
            end
            if (pop) begin
                check_entry();
                count++;
            end
            occ = redir_now ? 0 : occ + pending - pop;
            @(posedge clk_i);
            mem_rvalid_i  <= acc;
            mem_rdata_i   <= prog[acc_addr[9:2]];
            mem_ready_i   <= ($random(seed) & 3) != 0;
            fetch_ready_i <= ($random(seed) & 1) != 0;
            resolve_valid_i      <= 1'b0;
            resolve_mispredict_i <= 1'b0;
            eret_i               <= 1'b0;
            ex_valid_i           <= 1'b0;
            if (ev_idx < N_EVENTS && count >= ev_tab[ev_idx].key) begin
                e = ev_tab[ev_idx];
                ev_idx++;
                resolve_valid_i       <= e.res;
                resolve_conditional_i <= e.cond;
                resolve_pc_i          <= e.rpc;
                resolve_taken_i       <= e.taken;
                resolve_mispredict_i  <= e.misp;
                resolve_target_i      <= e.rtarget;
                eret_i                <= e.eret;
                epc_i                 <= e.epc;
                ex_valid_i            <= e.ex;
                trap_vector_i         <= e.trap;
                if (e.res && e.cond) begin
                    train_bht(e.rpc, e.taken);
                end
                if (e.ex || e.eret || (e.res && e.misp)) begin
                    exp_pc = e.exp_pc;
                end
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // each entry gets a generous budget of 40 cycles
    initial begin
        #(N_ENTRIES * 40 * CLK_PERIOD);
        failures++;
        $display("watchdog expired after %0d of %0d entries", count, N_ENTRIES);
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* hw/frontend.sv */
`default_nettype none
`timescale 1ns/100ps

module frontend import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [VLEN-1:0] boot_addr_i,
    // instruction memory
    output logic            mem_req_o,
    output logic [VLEN-1:0] mem_addr_o,
    input  logic            mem_ready_i,
    input  logic            mem_rvalid_i,
    input  logic [31:0]     mem_rdata_i,
    // branch resolution from execute
    input  logic            resolve_valid_i,
    input  logic            resolve_conditional_i,
    input  logic [VLEN-1:0] resolve_pc_i,
    input  logic            resolve_taken_i,
    input  logic            resolve_mispredict_i,
    input  logic [VLEN-1:0] resolve_target_i,
    // exception control
    input  logic            eret_i,
    input  logic [VLEN-1:0] epc_i,
    input  logic            ex_valid_i,
    input  logic [VLEN-1:0] trap_vector_i,
    // to the back end
    output logic            fetch_valid_o,
    input  logic            fetch_ready_i,
    output logic [VLEN-1:0] fetch_pc_o,
    output logic [31:0]     fetch_instr_o,
    output logic            fetch_taken_o,
    output logic [VLEN-1:0] fetch_target_o
);

    bp_resolve_if resolve ();
    pred_if       pred ();

    // queue can take the in-flight word and one more
    logic room;
    // exception, eret or mispredict this cycle
    logic redirect;

    assign resolve.valid       = resolve_valid_i;
    assign resolve.conditional = resolve_conditional_i;
    assign resolve.pc          = resolve_pc_i;
    assign resolve.taken       = resolve_taken_i;
    assign resolve.mispredict  = resolve_mispredict_i;
    assign resolve.target      = resolve_target_i;

    pc_gen i_pc_gen (
        .clk_i         ( clk_i         ),
        .rst_ni        ( rst_ni        ),
        .boot_addr_i   ( boot_addr_i   ),
        .resolve       ( resolve       ),
        .pred          ( pred          ),
        .eret_i        ( eret_i        ),
        .epc_i         ( epc_i         ),
        .ex_valid_i    ( ex_valid_i    ),
        .trap_vector_i ( trap_vector_i ),
        .room_i        ( room          ),
        .mem_req_o     ( mem_req_o     ),
        .mem_addr_o    ( mem_addr_o    ),
        .mem_ready_i   ( mem_ready_i   ),
        .redirect_o    ( redirect      )
    );

    // sees the address of every cycle, the response tells which was taken
    branch_predict i_branch_predict (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .mem_rvalid_i ( mem_rvalid_i ),
        .mem_rdata_i  ( mem_rdata_i  ),
        .mem_addr_i   ( mem_addr_o   ),
        .redirect_i   ( redirect     ),
        .resolve      ( resolve      ),
        .pred         ( pred         )
    );

    instr_queue i_instr_queue (
        .clk_i          ( clk_i          ),
        .rst_ni         ( rst_ni         ),
        .flush_i        ( redirect       ),
        .pred           ( pred           ),
        .room_o         ( room           ),
        .fetch_valid_o  ( fetch_valid_o  ),
        .fetch_ready_i  ( fetch_ready_i  ),
        .fetch_pc_o     ( fetch_pc_o     ),
        .fetch_instr_o  ( fetch_instr_o  ),
        .fetch_taken_o  ( fetch_taken_o  ),
        .fetch_target_o ( fetch_target_o )
    );

endmodule

`default_nettype wire

/* hw/instr_queue.sv */
`default_nettype none
`timescale 1ns/100ps

module instr_queue import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            flush_i,
    pred_if.queue_mp        pred,
    output logic            room_o,
    output logic            fetch_valid_o,
    input  logic            fetch_ready_i,
    output logic [VLEN-1:0] fetch_pc_o,
    output logic [31:0]     fetch_instr_o,
    output logic            fetch_taken_o,
    output logic [VLEN-1:0] fetch_target_o
);

    // entry storage
    logic [VLEN-1:0]        pc_q     [QUEUE_DEPTH];
    logic [31:0]            instr_q  [QUEUE_DEPTH];
    logic                   taken_q  [QUEUE_DEPTH];
    logic [VLEN-1:0]        target_q [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [QUEUE_CNT_W-1:0] count_q;
    logic                   push;
    logic                   pop;

    // pc_gen only requests with room, a response always fits
    assign push = pred.valid;
    assign pop  = fetch_valid_o & fetch_ready_i;

    // this cycle's write counts as done, one more slot for the next request
    assign room_o = (count_q + pred.valid) <= (QUEUE_DEPTH - 2);

    // show-ahead, head entry is visible without a read
    // nothing leaves in a flush cycle
    assign fetch_valid_o  = (count_q != '0) & ~flush_i;
    assign fetch_pc_o     = pc_q[rd_ptr_q];
    assign fetch_instr_o  = instr_q[rd_ptr_q];
    assign fetch_taken_o  = taken_q[rd_ptr_q];
    assign fetch_target_o = target_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else if (flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // pointers wrap on their own
            wr_ptr_q <= wr_ptr_q + QUEUE_PTR_W'(push);
            rd_ptr_q <= rd_ptr_q + QUEUE_PTR_W'(pop);
            count_q  <= count_q + QUEUE_CNT_W'(push) - QUEUE_CNT_W'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            pc_q[wr_ptr_q]     <= pred.pc;
            instr_q[wr_ptr_q]  <= pred.instr;
            taken_q[wr_ptr_q]  <= pred.taken;
            target_q[wr_ptr_q] <= pred.target;
        end
    end

endmodule

`default_nettype wire

/* hw/pc_gen.sv */
`default_nettype none
`timescale 1ns/100ps

module pc_gen import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [VLEN-1:0] boot_addr_i,
    bp_resolve_if.pcgen_mp  resolve,
    pred_if.pcgen_mp        pred,
    input  logic            eret_i,
    input  logic [VLEN-1:0] epc_i,
    input  logic            ex_valid_i,
    input  logic [VLEN-1:0] trap_vector_i,
    input  logic            room_i,
    output logic            mem_req_o,
    output logic [VLEN-1:0] mem_addr_o,
    input  logic            mem_ready_i,
    output logic            redirect_o
);

    logic [VLEN-1:0] npc_d;
    logic [VLEN-1:0] npc_q;
    // first cycle out of reset, npc picks up boot_addr_i
    logic            boot_load_q;
    logic            mispredict;
    logic            bp_taken;

    assign mispredict = resolve.valid & resolve.mispredict;
    assign bp_taken   = pred.valid & pred.taken;
    assign redirect_o = ex_valid_i | eret_i | mispredict;

    // a taken prediction replaces this cycle's fetch address,
    // so the fall-through word is never requested
    assign mem_addr_o = bp_taken ? pred.target : npc_q;
    // no request while a redirect is applied or npc is still unknown
    assign mem_req_o  = room_i & ~redirect_o & ~boot_load_q;

    // ------------------------------------------------------------------
    // next pc, later assignments take precedence
    // ------------------------------------------------------------------
    always_comb begin
        // hold, or keep the predicted target until it is accepted
        npc_d = mem_addr_o;
        if (mem_req_o && mem_ready_i) begin
            npc_d = mem_addr_o + INSTR_BYTES;
        end
        if (mispredict) begin
            npc_d = resolve.target;
        end
        if (eret_i) begin
            npc_d = epc_i;
        end
        if (ex_valid_i) begin
            npc_d = trap_vector_i;
        end
        if (boot_load_q) begin
            npc_d = boot_addr_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            boot_load_q <= 1'b1;
            npc_q       <= '0;
        end else begin
            boot_load_q <= 1'b0;
            npc_q       <= npc_d;
        end
    end

endmodule

`default_nettype wire

/* predict/branch_predict.sv */
`default_nettype none
`timescale 1ns/100ps

module branch_predict import fe_pkg::*, rv_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            mem_rvalid_i,
    input  logic [31:0]     mem_rdata_i,
    input  logic [VLEN-1:0] mem_addr_i,
    input  logic            redirect_i,
    bp_resolve_if.bht_mp    resolve,
    pred_if.src_mp          pred
);

    // address of last cycle's request, pc of any response now
    logic [VLEN-1:0] addr_q;
    rv_instr_t       instr;
    logic            valid;
    logic            is_branch;
    logic            is_jal;
    logic            is_jalr;
    logic            rd_link;
    logic            rs1_link;
    logic            is_call;
    logic            is_return;
    logic [VLEN-1:0] b_imm;
    logic [VLEN-1:0] j_imm;
    logic [VLEN-1:0] seq_pc;
    logic            bht_valid;
    logic            bht_taken;
    logic [VLEN-1:0] ras_top;
    logic            ras_empty;
    logic            taken;
    logic [VLEN-1:0] target;

    // latency is fixed at one cycle, so no need to look at the accept
    always_ff @(posedge clk_i) begin
        addr_q <= mem_addr_i;
    end

    assign instr  = mem_rdata_i;
    assign valid  = mem_rvalid_i & ~redirect_i;
    assign seq_pc = addr_q + INSTR_BYTES;

    // ------------------------------------------------------------------
    // control-flow scan
    // ------------------------------------------------------------------
    assign is_branch = (instr.b.opcode == OPC_BRANCH);
    assign is_jal    = (instr.j.opcode == OPC_JAL);
    assign is_jalr   = (instr.j.opcode == OPC_JALR);
    assign rd_link   = (instr.j.rd == REG_RA) || (instr.j.rd == REG_T0);
    assign rs1_link  = (instr.j.rs1 == REG_RA) || (instr.j.rs1 == REG_T0);
    assign is_call   = (is_jal | is_jalr) & rd_link;
    assign is_return = is_jalr & rs1_link & (instr.j.rd == REG_ZERO);

    // sign-extended offsets
    assign b_imm = {{(VLEN-12){instr.b.imm12}}, instr.b.imm11, instr.b.imm10_5,
                    instr.b.imm4_1, 1'b0};
    assign j_imm = {{(VLEN-20){instr.j.imm20}}, instr.j.rs1, instr.j.funct3,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    // ------------------------------------------------------------------
    // target selection
    // ------------------------------------------------------------------
    always_comb begin
        taken  = 1'b0;
        target = seq_pc;
        if (is_jal) begin
            taken  = 1'b1;
            target = addr_q + j_imm;
        end else if (is_branch) begin
            // static rule while the counter is cold, backward means taken
            taken = bht_valid ? bht_taken : b_imm[VLEN-1];
            if (taken) begin
                target = addr_q + b_imm;
            end
        end else if (is_return && !ras_empty) begin
            taken  = 1'b1;
            target = ras_top;
        end
    end

    assign pred.valid  = valid;
    assign pred.pc     = addr_q;
    assign pred.instr  = mem_rdata_i;
    assign pred.taken  = taken;
    assign pred.target = target;

    bht i_bht (
        .clk_i   ( clk_i     ),
        .rst_ni  ( rst_ni    ),
        .pc_i    ( addr_q    ),
        .valid_o ( bht_valid ),
        .taken_o ( bht_taken ),
        .resolve ( resolve   )
    );

    // discarded responses leave the stack alone
    ras i_ras (
        .clk_i   ( clk_i               ),
        .rst_ni  ( rst_ni              ),
        .push_i  ( valid & is_call     ),
        .pop_i   ( valid & is_return   ),
        .addr_i  ( seq_pc              ),
        .top_o   ( ras_top             ),
        .empty_o ( ras_empty           )
    );

endmodule

`default_nettype wire

/* predict/ras.sv */
`default_nettype none
`timescale 1ns/100ps

module ras import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic            push_i,
    input  logic            pop_i,
    input  logic [VLEN-1:0] addr_i,
    output logic [VLEN-1:0] top_o,
    output logic            empty_o
);

    // entry 0 is the top, deeper entries shift down on a push
    logic [VLEN-1:0]      stack_q [RAS_DEPTH];
    logic [RAS_CNT_W-1:0] count_q;
    logic                 replace;
    logic                 do_push;
    logic                 do_pop;

    assign top_o   = stack_q[0];
    assign empty_o = (count_q == '0);

    // pop on empty is ignored, push and pop together swap the top
    assign replace = push_i & pop_i & ~empty_o;
    assign do_push = push_i & ~replace;
    assign do_pop  = pop_i & ~push_i & ~empty_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= '0;
        end else if (do_push && count_q != RAS_CNT_W'(RAS_DEPTH)) begin
            count_q <= count_q + 1'b1;
        end else if (do_pop) begin
            count_q <= count_q - 1'b1;
        end
    end

    // full stack push drops the oldest entry off the bottom
    always_ff @(posedge clk_i) begin
        if (replace) begin
            stack_q[0] <= addr_i;
        end else if (do_push) begin
            stack_q[0] <= addr_i;
            for (int i = 1; i < RAS_DEPTH; i++) begin
                stack_q[i] <= stack_q[i-1];
            end
        end else if (do_pop) begin
            for (int i = 0; i < RAS_DEPTH - 1; i++) begin
                stack_q[i] <= stack_q[i+1];
            end
        end
    end

endmodule

`default_nettype wire

/* predict/bht.sv */
`default_nettype none
`timescale 1ns/100ps

module bht import fe_pkg::*; (
    input  logic            clk_i,
    input  logic            rst_ni,
    input  logic [VLEN-1:0] pc_i,
    output logic            valid_o,
    output logic            taken_o,
    bp_resolve_if.bht_mp    resolve
);

    // 2-bit saturating counters, msb is the prediction
    logic [1:0]             cnt_q [BHT_ENTRIES];
    logic [BHT_ENTRIES-1:0] valid_q;
    logic [BHT_IDX_W-1:0]   rd_idx;
    logic [BHT_IDX_W-1:0]   wr_idx;
    logic                   update;

    // word-aligned pcs, skip the two low bits
    assign rd_idx  = pc_i[BHT_IDX_W+1:2];
    assign wr_idx  = resolve.pc[BHT_IDX_W+1:2];
    assign update  = resolve.valid & resolve.conditional;
    assign valid_o = valid_q[rd_idx];
    assign taken_o = cnt_q[rd_idx][1];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
        end else if (update) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (update) begin
            if (!valid_q[wr_idx]) begin
                // first outcome lands on the weak side of its direction
                cnt_q[wr_idx] <= resolve.taken ? 2'b10 : 2'b01;
            end else if (resolve.taken && cnt_q[wr_idx] != 2'b11) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] + 2'd1;
            end else if (!resolve.taken && cnt_q[wr_idx] != 2'b00) begin
                cnt_q[wr_idx] <= cnt_q[wr_idx] - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* common/pred_if.sv */
`default_nettype none
`timescale 1ns/100ps

// fetched word plus its predicted successor
interface pred_if import fe_pkg::*; ();

    // response accepted, already cleared on a redirect
    logic            valid;
    logic [VLEN-1:0] pc;
    logic [31:0]     instr;
    logic            taken;
    // pc + 4 unless predicted taken
    logic [VLEN-1:0] target;

    modport src_mp (output valid, pc, instr, taken, target);
    modport pcgen_mp (input valid, taken, target);
    modport queue_mp (input valid, pc, instr, taken, target);

endinterface

`default_nettype wire

/* common/bp_resolve_if.sv */
`default_nettype none
`timescale 1ns/100ps

// branch outcome coming back from the execute stage
interface bp_resolve_if import fe_pkg::*; ();

    logic            valid;
    // conditional branch, trains the bht
    logic            conditional;
    logic [VLEN-1:0] pc;
    logic            taken;
    // front end went the wrong way, restart at target
    logic            mispredict;
    logic [VLEN-1:0] target;

    modport bht_mp (input valid, conditional, pc, taken);
    modport pcgen_mp (input valid, mispredict, target);

endinterface

`default_nettype wire

/* common/fe_pkg.sv */
`default_nettype none

package fe_pkg;

    // ------------------------------------------------------------------
    // address space
    // ------------------------------------------------------------------
    localparam int unsigned VLEN = 32;
    // sequential fetch step, one 32-bit word
    localparam logic [VLEN-1:0] INSTR_BYTES = 'd4;

    // ------------------------------------------------------------------
    // predictor sizes
    // ------------------------------------------------------------------
    localparam int unsigned BHT_ENTRIES = 16;
    localparam int unsigned BHT_IDX_W   = $clog2(BHT_ENTRIES);
    localparam int unsigned RAS_DEPTH   = 2;
    localparam int unsigned RAS_CNT_W   = $clog2(RAS_DEPTH + 1);

    // instruction queue, depth must be a power of two
    localparam int unsigned QUEUE_DEPTH = 4;
    localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

endpackage

`default_nettype wire

/* common/rv_pkg.sv */
`default_nettype none

package rv_pkg;

    // ------------------------------------------------------------------
    // major opcodes seen by the control-flow scan
    // ------------------------------------------------------------------
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    // register numbers for call and return detection
    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;
    localparam logic [4:0] REG_T0   = 5'd5;

    // one instruction word, looked at as a branch or as a jump
    typedef union packed {
        // B-type, immediate bits are scattered around rs1/rs2
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        // J-type and I-type share rd
        // for jal, rs1 and funct3 hold imm[19:15] and imm[14:12]
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_instr_t;

endpackage

`default_nettype wire
